// File: Bender.yml
package:
  name: apb_i2c_master

sources:
  # Packages first, then the blocks, then the top level
  - design/apbRegPkg.sv
  - design/i2cPkg.sv
  - design/apbDecode.sv
  - design/byteFifo.sv
  - design/i2cMaster.sv
  - design/apbI2cTop.sv

  # Testbench, top module apbI2cTb
  - target: test
    files:
      - verif/tbClock.sv
      - verif/apbI2cTb.sv

// File: design/apbDecode.sv
// APB slave decode with config and timeout registers, FIFO strobes and read mux
`timescale 1ns/1ps

module apbDecode
(
	input  logic                 PCLK,
	input  logic                 PRESETn,
	// APB slave side
	input  logic                 pSel,
	input  logic                 pEnable,
	input  logic                 pWrite,
	input  apbRegPkg::apbAddr    pAddr,
	input  apbRegPkg::apbData    pWData,
	output apbRegPkg::apbData    pRData,
	output logic                 pReady,
	output logic                 pSlvErr,
	// Interrupt levels
	output logic                 intTx,
	output logic                 intRx,
	// FIFO side
	input  i2cPkg::i2cByte       rxHead,
	input  logic                 rxEmpty,
	input  logic                 txEmpty,
	output logic                 txPush,
	output i2cPkg::i2cByte       txData,
	output logic                 rxPop,
	// Master side
	input  i2cPkg::i2cStatus     status,
	output apbRegPkg::cfgReg     cfg,
	output apbRegPkg::regField   timeoutLimit,
	output logic                 startPulse
);

	logic accessPhase;
	logic wrAccess;
	logic rdAccess;
	logic cfgWrite;
	logic toWrite;
	apbRegPkg::cfgReg cfgNext;

	//////////////////////////////////////////////////
	// Access decode
	//////////////////////////////////////////////////

	// Zero wait states so every access phase completes
	assign accessPhase = pSel && pEnable;
	assign pReady = accessPhase;
	assign wrAccess = accessPhase && pWrite;
	assign rdAccess = accessPhase && !pWrite;

	// One-cycle FIFO strobes
	assign txPush = wrAccess && (pAddr == apbRegPkg::addrTxFifo);
	assign txData = pWData[7:0];
	assign rxPop = rdAccess && (pAddr == apbRegPkg::addrRxFifo);

	// Register writes
	assign cfgWrite = wrAccess && (pAddr == apbRegPkg::addrConfig);
	assign toWrite = wrAccess && (pAddr == apbRegPkg::addrTimeout);
	assign cfgNext = apbRegPkg::cfgReg'(pWData[$bits(apbRegPkg::cfgReg)-1:0]);

	// Status and interrupt levels pass straight out
	assign pSlvErr = status.error;
	assign intTx = txEmpty;
	assign intRx = rxEmpty;

	//////////////////////////////////////////////////
	// Registers
	//////////////////////////////////////////////////

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			cfg <= '0;
			timeoutLimit <= '0;
			startPulse <= 1'b0;
		end
		else
		begin
			// A start request while busy is dropped here
			startPulse <= cfgWrite && cfgNext.enable && !status.busy;
			// Software write wins over the done clear
			if (cfgWrite)
				cfg <= cfgNext;
			else if (status.done)
				cfg.enable <= 1'b0;
			if (toWrite)
				timeoutLimit <= pWData[$bits(apbRegPkg::regField)-1:0];
		end
	end

	// Read data valid in the access cycle
	always_comb
	begin
		case (pAddr)
			apbRegPkg::addrRxFifo:  pRData = apbRegPkg::apbData'(rxHead);
			apbRegPkg::addrConfig:  pRData = apbRegPkg::apbData'(cfg);
			apbRegPkg::addrTimeout: pRData = apbRegPkg::apbData'(timeoutLimit);
			default:                pRData = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	// Ready only acknowledges an access phase that follows a setup phase
	assert property (@(posedge PCLK) disable iff (!PRESETn)
		pReady |-> $past(pSel && !pEnable));

	// A new start never overlaps the end of the previous transfer
	assert property (@(posedge PCLK) disable iff (!PRESETn)
		!(startPulse && status.done));

endmodule

// File: design/apbI2cTop.sv
// APB to I2C master top level joining decode, transmit and receive FIFOs and the master
`timescale 1ns/1ps

module apbI2cTop
(
	input  logic               PCLK,
	input  logic               PRESETn,
	// APB slave
	input  logic               pSel,
	input  logic               pEnable,
	input  logic               pWrite,
	input  apbRegPkg::apbAddr  pAddr,
	input  apbRegPkg::apbData  pWData,
	output apbRegPkg::apbData  pRData,
	output logic               pReady,
	output logic               pSlvErr,
	// Interrupts
	output logic               intTx,
	output logic               intRx,
	// Open-drain I2C pins
	output logic               sclLow,
	output logic               sdaLow,
	input  logic               sdaIn
);

	// Transmit path
	logic txPush;
	i2cPkg::i2cByte txData;
	i2cPkg::i2cByte txHead;
	logic txEmpty;
	logic txPop;

	// Receive path
	logic rxPush;
	i2cPkg::i2cByte rxData;
	i2cPkg::i2cByte rxHead;
	logic rxEmpty;
	logic rxPop;

	// Control between decode and master
	apbRegPkg::cfgReg cfg;
	apbRegPkg::regField timeoutLimit;
	logic startPulse;
	i2cPkg::i2cStatus status;

	//////////////////////////////////////////////////
	// Register block
	//////////////////////////////////////////////////

	apbDecode u_apbDecode (
		.PCLK(PCLK), .PRESETn(PRESETn),
		.pSel(pSel), .pEnable(pEnable), .pWrite(pWrite), .pAddr(pAddr), .pWData(pWData),
		.pRData(pRData), .pReady(pReady), .pSlvErr(pSlvErr),
		.intTx(intTx), .intRx(intRx),
		.rxHead(rxHead), .rxEmpty(rxEmpty), .txEmpty(txEmpty),
		.txPush(txPush), .txData(txData), .rxPop(rxPop),
		.status(status), .cfg(cfg), .timeoutLimit(timeoutLimit), .startPulse(startPulse)
	);

	// Software pushes, master pops
	byteFifo u_txFifo (
		.PCLK(PCLK), .PRESETn(PRESETn),
		.push(txPush), .pushData(txData), .pop(txPop),
		.head(txHead), .empty(txEmpty), .full()
	);

	// Master pushes, software pops
	byteFifo u_rxFifo (
		.PCLK(PCLK), .PRESETn(PRESETn),
		.push(rxPush), .pushData(rxData), .pop(rxPop),
		.head(rxHead), .empty(rxEmpty), .full()
	);

	i2cMaster u_i2cMaster (
		.PCLK(PCLK), .PRESETn(PRESETn),
		.startPulse(startPulse), .cfg(cfg), .timeoutLimit(timeoutLimit),
		.txHead(txHead), .txEmpty(txEmpty), .txPop(txPop),
		.rxPush(rxPush), .rxData(rxData),
		.status(status), .sclLow(sclLow), .sdaLow(sdaLow), .sdaIn(sdaIn)
	);

endmodule

// File: design/apbRegPkg.sv
// APB register map, bus word types and configuration register layout
package apbRegPkg;

	//////////////////////////////////////////////////
	// Bus word types
	//////////////////////////////////////////////////

	// Full APB address word
	typedef logic [31:0] apbAddr;

	// Full APB data word, read and write
	typedef logic [31:0] apbData;

	// Contents of the configuration and timeout registers
	typedef logic [13:0] regField;

	//////////////////////////////////////////////////
	// Register map
	//////////////////////////////////////////////////

	// Write pushes a byte into the transmit FIFO
	localparam apbAddr addrTxFifo = 32'd0;

	// Read pops a byte from the receive FIFO
	localparam apbAddr addrRxFifo = 32'd4;

	// Transfer configuration, enable bit starts a transfer
	localparam apbAddr addrConfig = 32'd8;

	// Transfer timeout in PCLK cycles, zero disables it
	localparam apbAddr addrTimeout = 32'd12;

	//////////////////////////////////////////////////
	// Configuration register
	//////////////////////////////////////////////////

	// Packed to the same 14 bits as regField, MSB first
	typedef struct packed {
		logic [4:0] byteCount;    // Data bytes after the address
		logic [6:0] slaveAddr;    // 7-bit target address
		logic       readNotWrite; // R/W bit sent with the address
		logic       enable;       // Set starts, cleared on done
	} cfgReg;

endpackage

// File: design/byteFifo.sv
// Synchronous byte FIFO with occupancy count, shared by transmit and receive paths
`timescale 1ns/1ps

module byteFifo
(
	input  logic           PCLK,
	input  logic           PRESETn,
	input  logic           push,
	input  i2cPkg::i2cByte pushData,
	input  logic           pop,
	output i2cPkg::i2cByte head,
	output logic           empty,
	output logic           full
);

	i2cPkg::i2cByte mem [i2cPkg::fifoDepth];
	i2cPkg::fifoPtr wrPtr;
	i2cPkg::fifoPtr rdPtr;
	i2cPkg::fifoCount count;
	logic doPush;
	logic doPop;

	// Drop pushes when full, ignore pops when empty
	assign doPush = push && !full;
	assign doPop = pop && !empty;

	assign empty = (count == '0);
	assign full = (count == i2cPkg::fifoCount'(i2cPkg::fifoDepth));

	// Head is visible without a pop
	assign head = mem[rdPtr];

	// Storage
	always_ff @(posedge PCLK)
	begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

	//////////////////////////////////////////////////
	// Pointers and occupancy
	//////////////////////////////////////////////////

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			// Pointers wrap on their own width
			if (doPush)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			// Push and pop together keep the count
			case ({doPush, doPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Overflow means lost data upstream
	assert property (@(posedge PCLK) disable iff (!PRESETn) push |-> !full);

	// Underflow means a read with nothing behind it
	assert property (@(posedge PCLK) disable iff (!PRESETn) pop |-> !empty);

endmodule

// File: design/i2cMaster.sv
// I2C master bit engine running one transfer with acknowledge and timeout checks
`timescale 1ns/1ps

module i2cMaster
(
	input  logic                PCLK,
	input  logic                PRESETn,
	input  logic                startPulse,
	input  apbRegPkg::cfgReg    cfg,
	input  apbRegPkg::regField  timeoutLimit,
	// Transmit FIFO
	input  i2cPkg::i2cByte      txHead,
	input  logic                txEmpty,
	output logic                txPop,
	// Receive FIFO
	output logic                rxPush,
	output i2cPkg::i2cByte      rxData,
	// Status and bus pins
	output i2cPkg::i2cStatus    status,
	output logic                sclLow,
	output logic                sdaLow,
	input  logic                sdaIn
);

	i2cPkg::i2cState state;
	logic [$clog2(i2cPkg::sclHalf)-1:0] divCnt;
	logic halfTick;
	logic [2:0] bitCnt;
	logic [4:0] byteLeft;
	logic rnw;
	i2cPkg::i2cByte shiftReg;
	i2cPkg::i2cByte nextTx;
	apbRegPkg::regField toCnt;
	logic timedOut;

	// End of an SCL half period
	assign halfTick = (divCnt == $bits(divCnt)'(i2cPkg::sclHalf - 1));

	// Empty transmit FIFO sends zeros
	assign nextTx = txEmpty ? '0 : txHead;

	// Received byte sits in the shifter
	assign rxData = shiftReg;

	// Timeout never cuts into an ongoing STOP
	assign timedOut = (timeoutLimit != '0) && (toCnt >= timeoutLimit) &&
		(state != i2cPkg::idle) && (state != i2cPkg::stop);

	//////////////////////////////////////////////////
	// Transfer FSM
	//////////////////////////////////////////////////

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			state <= i2cPkg::idle;
			divCnt <= '0;
			bitCnt <= '0;
			byteLeft <= '0;
			rnw <= 1'b0;
			shiftReg <= '0;
			toCnt <= '0;
			txPop <= 1'b0;
			rxPush <= 1'b0;
			status <= '0;
			sclLow <= 1'b0;
			sdaLow <= 1'b0;
		end
		else
		begin
			// Strobes default low
			txPop <= 1'b0;
			rxPush <= 1'b0;
			status.done <= 1'b0;
			// Divider and timeout run only inside a transfer
			if (state == i2cPkg::idle)
				divCnt <= '0;
			else
			begin
				divCnt <= halfTick ? '0 : divCnt + 1'b1;
				toCnt <= toCnt + 1'b1;
			end
			if (timedOut)
			begin
				// Abort, pull both lines low and close with STOP
				status.error <= 1'b1;
				sclLow <= 1'b1;
				sdaLow <= 1'b1;
				divCnt <= '0;
				bitCnt <= '0;
				state <= i2cPkg::stop;
			end
			else
			begin
				case (state)
					i2cPkg::idle:
					begin
						if (startPulse && cfg.enable)
						begin
							// START: SDA falls while SCL is released
							sdaLow <= 1'b1;
							shiftReg <= {cfg.slaveAddr, cfg.readNotWrite};
							byteLeft <= cfg.byteCount;
							rnw <= cfg.readNotWrite;
							bitCnt <= '0;
							toCnt <= '0;
							status.busy <= 1'b1;
							status.error <= 1'b0;
							state <= i2cPkg::start;
						end
					end
					i2cPkg::start:
					begin
						// Hold START, then SCL low with the address MSB
						if (halfTick)
						begin
							sclLow <= 1'b1;
							sdaLow <= ~shiftReg[7];
							state <= i2cPkg::sendByte;
						end
					end
					i2cPkg::sendByte:
					begin
						if (halfTick)
						begin
							if (sclLow)
								sclLow <= 1'b0;
							else
							begin
								sclLow <= 1'b1;
								if (bitCnt == 3'd7)
								begin
									// Release SDA for the slave ACK
									bitCnt <= '0;
									sdaLow <= 1'b0;
									state <= i2cPkg::getAck;
								end
								else
								begin
									bitCnt <= bitCnt + 1'b1;
									shiftReg <= {shiftReg[6:0], 1'b0};
									sdaLow <= ~shiftReg[6];
								end
							end
						end
					end
					i2cPkg::getAck:
					begin
						if (halfTick)
						begin
							if (sclLow)
								sclLow <= 1'b0;
							else
							begin
								sclLow <= 1'b1;
								if (sdaIn)
								begin
									// NACK ends the transfer with an error
									status.error <= 1'b1;
									sdaLow <= 1'b1;
									state <= i2cPkg::stop;
								end
								else if (byteLeft == '0)
								begin
									sdaLow <= 1'b1;
									state <= i2cPkg::stop;
								end
								else if (rnw)
								begin
									byteLeft <= byteLeft - 1'b1;
									state <= i2cPkg::recvByte;
								end
								else
								begin
									// Load next write byte, MSB goes out now
									byteLeft <= byteLeft - 1'b1;
									shiftReg <= nextTx;
									txPop <= !txEmpty;
									sdaLow <= ~nextTx[7];
									state <= i2cPkg::sendByte;
								end
							end
						end
					end
					i2cPkg::recvByte:
					begin
						if (halfTick)
						begin
							if (sclLow)
								sclLow <= 1'b0;
							else
							begin
								// Sample at the end of SCL high
								sclLow <= 1'b1;
								shiftReg <= {shiftReg[6:0], sdaIn};
								if (bitCnt == 3'd7)
								begin
									bitCnt <= '0;
									rxPush <= 1'b1;
									// ACK all but the last byte
									sdaLow <= (byteLeft != '0);
									state <= i2cPkg::putAck;
								end
								else
									bitCnt <= bitCnt + 1'b1;
							end
						end
					end
					i2cPkg::putAck:
					begin
						if (halfTick)
						begin
							if (sclLow)
								sclLow <= 1'b0;
							else
							begin
								sclLow <= 1'b1;
								if (byteLeft == '0)
								begin
									sdaLow <= 1'b1;
									state <= i2cPkg::stop;
								end
								else
								begin
									byteLeft <= byteLeft - 1'b1;
									sdaLow <= 1'b0;
									state <= i2cPkg::recvByte;
								end
							end
						end
					end
					i2cPkg::stop:
					begin
						// SCL rises first, then SDA rises for STOP
						if (halfTick)
						begin
							if (sclLow)
								sclLow <= 1'b0;
							else
							begin
								sdaLow <= 1'b0;
								status.busy <= 1'b0;
								status.done <= 1'b1;
								state <= i2cPkg::idle;
							end
						end
					end
					default: state <= i2cPkg::idle;
				endcase
			end
		end
	end

	// SDA moves only with SCL low, START and STOP excepted
	assert property (@(posedge PCLK) disable iff (!PRESETn)
		$changed(sdaLow) |-> sclLow || (state == i2cPkg::start) ||
			($past(state) == i2cPkg::stop));

	// Completion is a single pulse
	assert property (@(posedge PCLK) disable iff (!PRESETn) status.done |=> !status.done);

endmodule

// File: design/i2cPkg.sv
// I2C data, FIFO sizing, bus timing and master state definitions
package i2cPkg;

	//////////////////////////////////////////////////
	// Data and FIFO sizing
	//////////////////////////////////////////////////

	// One byte on the I2C bus
	typedef logic [7:0] i2cByte;

	// Depth shared by the transmit and receive FIFOs
	localparam int fifoDepth = 8;

	// Read and write pointers, wrap at fifoDepth
	typedef logic [2:0] fifoPtr;

	// Occupancy, one bit wider to hold a full count
	typedef logic [3:0] fifoCount;

	//////////////////////////////////////////////////
	// Bus timing
	//////////////////////////////////////////////////

	// PCLK cycles in each SCL half period
	localparam int sclHalf = 4;

	//////////////////////////////////////////////////
	// Master control
	//////////////////////////////////////////////////

	// Transfer sequencing of the bit engine
	typedef enum logic [2:0] {
		idle,
		start,
		sendByte,
		getAck,
		recvByte,
		putAck,
		stop
	} i2cState;

	// Status back to the register block
	typedef struct packed {
		logic busy;  // Transfer in progress
		logic done;  // One-cycle pulse at the end of STOP
		logic error; // NACK or timeout, held until next start
	} i2cStatus;

endpackage

// File: sources.f
design/apbRegPkg.sv
design/i2cPkg.sv
design/apbDecode.sv
design/byteFifo.sv
design/i2cMaster.sv
design/apbI2cTop.sv
verif/tbClock.sv
verif/apbI2cTb.sv

// File: verif/apbI2cTb.sv
// Table-driven testbench with APB driver, I2C slave model and compare tasks
`timescale 1ns/1ps

module apbI2cTb;

	typedef enum logic {regRow, xferRow} rowKind;

	// Reg rows use addr as the APB address and transfer rows as the slave address
	typedef struct packed {
		rowKind kind;
		apbRegPkg::apbAddr addr;
		logic rnw;
		logic [4:0] byteCount;
		apbRegPkg::apbData data;    // First byte in the low lane
		logic ackAddr;
		apbRegPkg::regField timeout;
		logic expErr;
	} stimRow;

	localparam int numRows = 9;

	stimRow stimTable [numRows] = '{
		'{regRow,  32'h8,  1'b0, 5'd0, 32'hFFFF_3FFE, 1'b1, 14'd0,    1'b0},
		'{regRow,  32'hC,  1'b0, 5'd0, 32'hFFFF_D5A7, 1'b1, 14'd0,    1'b0},
		'{regRow,  32'h20, 1'b0, 5'd0, 32'hDEAD_BEEF, 1'b1, 14'd0,    1'b0},
		'{xferRow, 32'h52, 1'b0, 5'd3, 32'h000F_3CA5, 1'b1, 14'd0,    1'b0},
		'{xferRow, 32'h29, 1'b1, 5'd4, 32'h7B00_E196, 1'b1, 14'd0,    1'b0},
		'{xferRow, 32'h11, 1'b1, 5'd2, 32'h0000_3344, 1'b0, 14'd0,    1'b1},
		'{xferRow, 32'h52, 1'b0, 5'd1, 32'h0000_00C3, 1'b1, 14'd2000, 1'b0},
		'{xferRow, 32'h29, 1'b1, 5'd2, 32'h0000_815A, 1'b1, 14'd20,   1'b1},
		'{xferRow, 32'h29, 1'b1, 5'd2, 32'h0000_815A, 1'b1, 14'd0,    1'b0}
	};

	logic PCLK;
	logic PRESETn;
	logic pSel;
	logic pEnable;
	logic pWrite;
	apbRegPkg::apbAddr pAddr;
	apbRegPkg::apbData pWData;
	apbRegPkg::apbData pRData;
	logic pReady;
	logic pSlvErr;
	logic intTx;
	logic intRx;
	logic sclLow;
	logic sdaLow;
	logic sdaIn;
	int errors = 0;
	int cycles;

	// Slave model state
	logic sclBus;
	logic sdaBus;
	logic slvLow = 1'b0;
	logic prevScl;
	logic prevSda;
	logic active;
	logic mute;
	logic seenRnw;
	int bitIdx;
	int byteIdx;
	int stopCount;
	i2cPkg::i2cByte shiftIn;
	i2cPkg::i2cByte capQ [$];
	logic curAck;
	apbRegPkg::apbData curData;

	tbClock u_tbClock (.PCLK(PCLK), .PRESETn(PRESETn));

	apbI2cTop u_apbI2cTop (
		.PCLK(PCLK), .PRESETn(PRESETn),
		.pSel(pSel), .pEnable(pEnable), .pWrite(pWrite), .pAddr(pAddr), .pWData(pWData),
		.pRData(pRData), .pReady(pReady), .pSlvErr(pSlvErr),
		.intTx(intTx), .intRx(intRx),
		.sclLow(sclLow), .sdaLow(sdaLow), .sdaIn(sdaIn)
	);

	//////////////////////////////////////////////////
	// I2C slave model
	//////////////////////////////////////////////////

	// Pull-ups on both lines and either side may pull SDA low
	assign sclBus = !sclLow;
	assign sdaBus = !(sdaLow || slvLow);
	assign sdaIn = sdaBus;

	// Level the slave puts on SDA for the coming bit
	function automatic logic driveLow(int bitNo, int byteNo);
		if (mute)
			return 1'b0;
		// The address ack follows the row, write data is always acked
		// and read data is acked by the master
		if (bitNo == 8)
			return (byteNo == 0) ? curAck : !seenRnw;
		if (seenRnw && byteNo >= 1 && byteNo <= 4)
			return !curData[8*(byteNo-1) + 7 - bitNo];
		return 1'b0;
	endfunction

	always @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			prevScl <= 1'b1;
			prevSda <= 1'b1;
			active <= 1'b0;
			mute <= 1'b0;
			seenRnw <= 1'b0;
			slvLow <= 1'b0;
			bitIdx <= 0;
			byteIdx <= 0;
			stopCount <= 0;
		end
		else
		begin
			prevScl <= sclBus;
			prevSda <= sdaBus;
			if (prevScl && sclBus && prevSda && !sdaBus)
			begin
				// START
				active <= 1'b1;
				mute <= 1'b0;
				slvLow <= 1'b0;
				bitIdx <= 0;
				byteIdx <= 0;
				capQ.delete();
			end
			else if (prevScl && sclBus && !prevSda && sdaBus)
			begin
				// STOP
				active <= 1'b0;
				slvLow <= 1'b0;
				stopCount <= stopCount + 1;
			end
			else if (active && !prevScl && sclBus)
			begin
				// Data is stable once SCL has risen
				if (bitIdx == 8)
				begin
					// NACK from either side silences the slave
					if (sdaBus)
						mute <= 1'b1;
					bitIdx <= 0;
					byteIdx <= byteIdx + 1;
				end
				else
				begin
					shiftIn <= {shiftIn[6:0], sdaBus};
					if (bitIdx == 7)
						capQ.push_back({shiftIn[6:0], sdaBus});
					if (bitIdx == 7 && byteIdx == 0)
						seenRnw <= sdaBus;
					bitIdx <= bitIdx + 1;
				end
			end
			else if (active && prevScl && !sclBus)
				slvLow <= driveLow(bitIdx, byteIdx);
		end
	end

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////

	task automatic checkData(input string name, input apbRegPkg::apbData got,
		input apbRegPkg::apbData exp);
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
		end
	endtask

	task automatic checkByte(input string name, input i2cPkg::i2cByte got,
		input i2cPkg::i2cByte exp);
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %s got 0x%02h expected 0x%02h", name, got, exp);
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	//////////////////////////////////////////////////
	// APB driver
	//////////////////////////////////////////////////

	task automatic apbWrite(input apbRegPkg::apbAddr addr, input apbRegPkg::apbData data);
		@(posedge PCLK);
		pSel <= 1'b1;
		pWrite <= 1'b1;
		pAddr <= addr;
		pWData <= data;
		@(posedge PCLK);
		pEnable <= 1'b1;
		@(negedge PCLK);
		checkFlag("pReady", pReady, 1'b1);
		@(posedge PCLK);
		pSel <= 1'b0;
		pEnable <= 1'b0;
		pWrite <= 1'b0;
	endtask

	task automatic apbRead(input apbRegPkg::apbAddr addr, output apbRegPkg::apbData data);
		@(posedge PCLK);
		pSel <= 1'b1;
		pWrite <= 1'b0;
		pAddr <= addr;
		@(posedge PCLK);
		pEnable <= 1'b1;
		// Read data is valid inside the access phase
		@(negedge PCLK);
		checkFlag("pReady", pReady, 1'b1);
		data = pRData;
		@(posedge PCLK);
		pSel <= 1'b0;
		pEnable <= 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Row runners
	//////////////////////////////////////////////////

	// Only config and timeout hold their low 14 bits and the rest reads 0
	task automatic checkRegister(input stimRow r);
		apbRegPkg::apbData rd;
		apbRegPkg::apbData expData;
		apbWrite(r.addr, r.data);
		apbRead(r.addr, rd);
		if (r.addr == apbRegPkg::addrConfig || r.addr == apbRegPkg::addrTimeout)
			expData = r.data & 32'h0000_3FFF;
		else
			expData = '0;
		checkData("pRData", rd, expData);
	endtask

	task automatic runTransfer(input stimRow r);
		apbRegPkg::cfgReg c;
		apbRegPkg::apbData rd;
		int stopsBefore;
		int expBytes;
		curAck = r.ackAddr;
		curData = r.data;
		stopsBefore = stopCount;
		apbWrite(apbRegPkg::addrTimeout, apbRegPkg::apbData'(r.timeout));
		if (!r.rnw)
		begin
			for (int i = 0; i < r.byteCount; i++)
				apbWrite(apbRegPkg::addrTxFifo, apbRegPkg::apbData'(r.data[8*i +: 8]));
			@(negedge PCLK);
			checkFlag("intTx", intTx, r.byteCount == 0);
		end
		c = '{byteCount: r.byteCount, slaveAddr: r.addr[6:0], readNotWrite: r.rnw, enable: 1'b1};
		apbWrite(apbRegPkg::addrConfig, apbRegPkg::apbData'(c));
		// Enable drops when the transfer is done
		do
			apbRead(apbRegPkg::addrConfig, rd);
		while (rd[0]);
		@(negedge PCLK);
		checkFlag("pSlvErr", pSlvErr, r.expErr);
		checkFlag("intTx", intTx, 1'b1);
		if (stopCount != stopsBefore + 1)
		begin
			errors++;
			$display("ERROR: transfer to slave 0x%02h did not end with a STOP", r.addr[6:0]);
		end
		// Address NACK leaves only the address byte on the bus and a timeout is cut short
		expBytes = r.expErr ? 1 : int'(r.byteCount) + 1;
		if (!(r.expErr && r.ackAddr))
		begin
			if (capQ.size() != expBytes)
			begin
				errors++;
				$display("ERROR: slave saw %0d bytes, expected %0d", capQ.size(), expBytes);
			end
			else
			begin
				checkByte("address byte", capQ[0], {r.addr[6:0], r.rnw});
				for (int i = 1; i < expBytes; i++)
					checkByte($sformatf("bus byte %0d", i), capQ[i], r.data[8*(i-1) +: 8]);
			end
		end
		if (r.rnw && !r.expErr && r.byteCount != 0)
		begin
			checkFlag("intRx", intRx, 1'b0);
			for (int i = 0; i < r.byteCount; i++)
			begin
				apbRead(apbRegPkg::addrRxFifo, rd);
				checkData("pRData", rd, apbRegPkg::apbData'(r.data[8*i +: 8]));
			end
			@(negedge PCLK);
		end
		checkFlag("intRx", intRx, 1'b1);
	endtask

	// Bit time of every row plus fixed slack for APB traffic
	function automatic int runLimit();
		int total;
		total = 200;
		for (int i = 0; i < numRows; i++)
			total += (int'(stimTable[i].byteCount) + 1) * 9 * 2 * i2cPkg::sclHalf;
		return total;
	endfunction

	//////////////////////////////////////////////////
	// Sequence and watchdog
	//////////////////////////////////////////////////

	initial
	begin
		apbRegPkg::apbData rd;
		pSel = 1'b0;
		pEnable = 1'b0;
		pWrite = 1'b0;
		pAddr = '0;
		pWData = '0;
		wait (PRESETn === 1'b1);
		@(negedge PCLK);
		// Quiet bus and empty FIFOs out of reset
		checkFlag("intTx", intTx, 1'b1);
		checkFlag("intRx", intRx, 1'b1);
		checkFlag("pSlvErr", pSlvErr, 1'b0);
		checkFlag("sclLow", sclLow, 1'b0);
		checkFlag("sdaLow", sdaLow, 1'b0);
		apbRead(apbRegPkg::addrConfig, rd);
		checkData("pRData", rd, '0);
		apbRead(apbRegPkg::addrTimeout, rd);
		checkData("pRData", rd, '0);
		for (int i = 0; i < numRows; i++)
		begin
			if (stimTable[i].kind == regRow)
				checkRegister(stimTable[i]);
			else
				runTransfer(stimTable[i]);
		end
		$display("Run complete with %0d errors", errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin
		for (cycles = 0; cycles < runLimit(); cycles++)
			@(posedge PCLK);
		$display("ERROR: run passed %0d cycles, a transfer never completed", runLimit());
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: verif/tbClock.sv
// Testbench clock and reset generator for the APB I2C master
`timescale 1ns/1ps

module tbClock
(
	output logic PCLK,
	output logic PRESETn
);

	// 4 ns period
	initial
	begin
		PCLK = 1'b0;
		forever #2 PCLK = ~PCLK;
	end

	// Synchronous reset, low for the first 16 rising edges
	initial
	begin
		PRESETn = 1'b0;
		repeat (16) @(posedge PCLK);
		PRESETn <= 1'b1;
	end

endmodule
